// ==== vlog.f ====
+incdir+bench
verilog/ip_pkg.sv
verilog/ip_decode.sv
verilog/ip_execute.sv
verilog/ip_result.sv
verilog/ip_mul_add.sv
bench/tb_ip_mul_add.sv

// ==== Bender.yml ====
package:
  name: ip_mul_add

sources:
  - files:
      - verilog/ip_pkg.sv
      - verilog/ip_decode.sv
      - verilog/ip_execute.sv
      - verilog/ip_result.sv
      - verilog/ip_mul_add.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_ip_mul_add.sv

// ==== bench/ip_model.svh ====
`ifndef IP_MODEL_SVH
`define IP_MODEL_SVH

// reverse the byte lanes of one word, lane 0 ends up on top
function automatic ip_pkg::word_u reverse_bytes(input ip_pkg::word_u w);
    ip_pkg::word_u r;
    r.bytes = {w.bytes[0], w.bytes[1], w.bytes[2], w.bytes[3]};
    return r;
endfunction

// fixed-point product with the low bits kept so overflow wraps
function automatic logic signed [ip_pkg::WORD_W-1:0] fixed_product(
    input logic signed [ip_pkg::WORD_W-1:0] d,
    input logic signed [ip_pkg::WORD_W-1:0] w
);
    logic signed [2*ip_pkg::WORD_W-1:0] p;
    p = $signed(d) * $signed(w);
    return p[ip_pkg::FRAC_W +: ip_pkg::WORD_W];
endfunction

function automatic logic [ip_pkg::WORD_W-1:0] relu_clamp(
    input logic signed [ip_pkg::WORD_W-1:0] s,
    input logic                             relu_en
);
    return (relu_en && s < 0) ? '0 : s;
endfunction

// address of the output after the one at addr
function automatic int addr_after(input int addr, input int onn);
    return (addr == onn - 1) ? 0 : (addr + 1) % 4096;
endfunction

`endif

// ==== bench/tb_ip_mul_add.sv ====
`timescale 1ns/1ps

module tb_ip_mul_add;
    import ip_pkg::*;

    `include "ip_model.svh"

    logic               clk_i;
    logic               rstn_i;
    logic [1:0]         bend_i;
    logic               relu_en_i;
    logic [CNT_W-1:0]   onn_i;
    logic               bias_valid_i;
    logic               data_valid_i;
    logic               weight_valid_i;
    logic               neuron_done_i;
    logic [WORD_W-1:0]  bias_i;
    logic [WORD_W-1:0]  data_i;
    logic [WORD_W-1:0]  weight_i;
    logic               output_valid_o;
    logic [WORD_W-1:0]  accum_data_o;
    logic [ADDR_W-1:0]  accum_addr_o;

    int                 cyc;
    int                 errors;
    int                 tests_run;
    int                 tests_passed;
    int                 next_addr;
    logic [WORD_W-1:0]  exp_data_q[$];
    int                 exp_addr_q[$];
    int                 exp_cyc_q[$];
    logic [WORD_W-1:0]  chk_data;
    int                 chk_addr;
    int                 chk_cyc;

    ip_mul_add u_dut (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .bend_i         (bend_i),
        .relu_en_i      (relu_en_i),
        .onn_i          (onn_i),
        .bias_valid_i   (bias_valid_i),
        .data_valid_i   (data_valid_i),
        .weight_valid_i (weight_valid_i),
        .neuron_done_i  (neuron_done_i),
        .bias_i         (bias_i),
        .data_i         (data_i),
        .weight_i       (weight_i),
        .output_valid_o (output_valid_o),
        .accum_data_o   (accum_data_o),
        .accum_addr_o   (accum_addr_o)
    );

    always #5 clk_i = ~clk_i;

    // edge counter that the checker reads at the falling edge
    always @(posedge clk_i) begin
        cyc <= cyc + 1;
    end

    //======================================================================
    //  output checker
    //======================================================================
    always @(negedge clk_i) begin
        if (output_valid_o === 1'b1) begin
            if (exp_data_q.size() == 0) begin
                $display("output_valid_o rose at %0t with no neuron pending", $time);
                errors++;
            end else begin
                chk_data = exp_data_q.pop_front();
                chk_addr = exp_addr_q.pop_front();
                chk_cyc  = exp_cyc_q.pop_front();
                assert (cyc == chk_cyc) else begin
                    $display("Fail %0t: output in cycle %0d, expected cycle %0d",
                             $time, cyc, chk_cyc);
                    errors++;
                end
                assert (accum_data_o === chk_data) else begin
                    $display("Fail %0t: data expected %h, got %h", $time, chk_data, accum_data_o);
                    errors++;
                end
                assert (accum_addr_o === chk_addr[ADDR_W-1:0]) else begin
                    $display("Fail %0t: address expected %0d, got %0d",
                             $time, chk_addr, accum_addr_o);
                    errors++;
                end
            end
        end
    end

    //======================================================================
    //  stimulus
    //======================================================================
    // roughly -8.0 to 8.0 in Q15.16
    function automatic logic signed [WORD_W-1:0] small_word();
        logic [19:0] r;
        r = $urandom;
        return {{(WORD_W-20){r[19]}}, r};
    endfunction

    task automatic clear_strobes();
        bias_valid_i   <= 1'b0;
        data_valid_i   <= 1'b0;
        weight_valid_i <= 1'b0;
        neuron_done_i  <= 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk_i);
            clear_strobes();
        end
    endtask

    task automatic apply_reset();
        rstn_i <= 1'b0;
        clear_strobes();
        repeat (8) @(posedge clk_i);
        rstn_i <= 1'b1;
        next_addr = 0;
    endtask

    task automatic configure(input logic [1:0] b, input logic r, input int n);
        @(posedge clk_i);
        clear_strobes();
        bend_i    <= b;
        relu_en_i <= r;
        onn_i     <= CNT_W'(n);
    endtask

    // random strobes and operands for one cycle while the model keeps the running sum
    task automatic drive_term(inout logic signed [WORD_W-1:0] acc);
        logic  dv;
        logic  wv;
        word_u d;
        word_u w;
        dv = ($urandom_range(3) != 0);
        wv = ($urandom_range(3) != 0);
        d.word = small_word();
        w.word = small_word();
        data_valid_i   <= dv;
        weight_valid_i <= wv;
        data_i         <= bend_i[0] ? d : reverse_bytes(d);
        weight_i       <= bend_i[1] ? w : reverse_bytes(w);
        if (dv && wv) begin
            acc = acc + fixed_product(d.word, w.word);
        end
    endtask

    task automatic run_neuron(input int len);
        word_u                    b;
        logic signed [WORD_W-1:0] acc;
        b.word = small_word();
        acc = b.word;
        @(posedge clk_i);
        bias_valid_i  <= 1'b1;
        neuron_done_i <= 1'b0;
        bias_i        <= bend_i[1] ? b : reverse_bytes(b);
        drive_term(acc);
        repeat (len) begin
            @(posedge clk_i);
            bias_valid_i <= 1'b0;
            drive_term(acc);
        end
        @(posedge clk_i);
        bias_valid_i  <= 1'b0;
        neuron_done_i <= 1'b1;
        drive_term(acc);
        // done is sampled on the next edge and the output follows three edges later
        exp_cyc_q.push_back(cyc + 5);
        exp_data_q.push_back(relu_clamp(acc, relu_en_i));
        exp_addr_q.push_back(next_addr);
        next_addr = addr_after(next_addr, int'(onn_i));
    endtask

    task automatic run_neurons(input int count, input bit gaps);
        for (int i = 0; i < count; i++) begin
            run_neuron($urandom_range(6));
            if (gaps) begin
                idle($urandom_range(3, 1));
            end
        end
        idle(1);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_data_q.size() != 0 && waited < 50) begin
            @(posedge clk_i);
            waited++;
        end
        if (exp_data_q.size() != 0) begin
            $display("timeout: %0d outputs never arrived within 50 cycles", exp_data_q.size());
            errors++;
            exp_data_q.delete();
            exp_addr_q.delete();
            exp_cyc_q.delete();
        end
    endtask

    task automatic check_idle(input int n);
        repeat (n) begin
            @(negedge clk_i);
            assert (output_valid_o === 1'b0 && accum_data_o === '0 && accum_addr_o === '0)
            else begin
                $display("Fail %0t: outputs not idle after reset, valid %b data %h addr %h",
                         $time, output_valid_o, accum_data_o, accum_addr_o);
                errors++;
            end
        end
    endtask

    task automatic finish_test(input string name, input int err_start);
        wait_drain();
        tests_run++;
        if (errors == err_start) begin
            tests_passed++;
            $display("%-14s passed", name);
        end else begin
            $display("%-14s failed with %0d errors", name, errors - err_start);
        end
    endtask

    //======================================================================
    //  test sequence
    //======================================================================
    initial begin
        int err_start;
        clk_i          = 1'b0;
        rstn_i         = 1'b0;
        bend_i         = 2'b11;
        relu_en_i      = 1'b0;
        onn_i          = CNT_W'(4096);
        bias_valid_i   = 1'b0;
        data_valid_i   = 1'b0;
        weight_valid_i = 1'b0;
        neuron_done_i  = 1'b0;
        bias_i         = '0;
        data_i         = '0;
        weight_i       = '0;
        cyc            = 0;
        errors         = 0;
        tests_run      = 0;
        tests_passed   = 0;
        next_addr      = 0;
        void'($urandom(32'h5523a24f));
        apply_reset();

        err_start = errors;
        check_idle(4);
        finish_test("reset_idle", err_start);

        err_start = errors;
        configure(2'b11, 1'b0, 4096);
        run_neurons(10, 1'b1);
        finish_test("plain_mac", err_start);

        err_start = errors;
        for (int b = 0; b < 4; b++) begin
            configure(2'(b), 1'b0, 4096);
            run_neurons(4, 1'b1);
            wait_drain();
        end
        finish_test("byte_order", err_start);

        err_start = errors;
        configure(2'b11, 1'b1, 4096);
        run_neurons(12, 1'b1);
        finish_test("relu", err_start);

        // next bias right after each done keeps two neurons in flight
        err_start = errors;
        configure(2'b11, 1'b0, 4096);
        run_neurons(8, 1'b0);
        finish_test("back_to_back", err_start);

        err_start = errors;
        apply_reset();
        configure(2'b11, 1'b0, 5);
        run_neurons(12, 1'b1);
        finish_test("addr_wrap", err_start);

        $display("%0d tests run, %0d passed, %0d errors", tests_run, tests_passed, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== verilog/ip_mul_add.sv ====
`timescale 1ns/1ps

module ip_mul_add (
    input  logic                             clk_i,
    input  logic                             rstn_i,
    input  logic [1:0]                       bend_i,
    input  logic                             relu_en_i,
    input  logic [ip_pkg::CNT_W-1:0]         onn_i,
    input  logic                             bias_valid_i,
    input  logic                             data_valid_i,
    input  logic                             weight_valid_i,
    input  logic                             neuron_done_i,
    input  logic [ip_pkg::WORD_W-1:0]        bias_i,
    input  logic [ip_pkg::WORD_W-1:0]        data_i,
    input  logic [ip_pkg::WORD_W-1:0]        weight_i,
    output logic                             output_valid_o,
    output logic [ip_pkg::WORD_W-1:0]        accum_data_o,
    output logic [ip_pkg::ADDR_W-1:0]        accum_addr_o
);
    import ip_pkg::*;

    // decode to execute
    logic                     dec_bias_valid;
    logic                     dec_term_valid;
    logic                     dec_done;
    word_u                    dec_bias;
    word_u                    dec_data;
    word_u                    dec_weight;

    // execute to result
    logic                     exe_sum_valid;
    logic signed [WORD_W-1:0] exe_sum;

    //======================================================================
    //  pipeline: decode, execute, result
    //======================================================================
    ip_decode u_decode (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .bend_i         (bend_i),
        .bias_valid_i   (bias_valid_i),
        .data_valid_i   (data_valid_i),
        .weight_valid_i (weight_valid_i),
        .neuron_done_i  (neuron_done_i),
        .bias_i         (bias_i),
        .data_i         (data_i),
        .weight_i       (weight_i),
        .bias_valid_o   (dec_bias_valid),
        .term_valid_o   (dec_term_valid),
        .done_o         (dec_done),
        .bias_o         (dec_bias),
        .data_o         (dec_data),
        .weight_o       (dec_weight)
    );

    ip_execute u_execute (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .bias_valid_i   (dec_bias_valid),
        .term_valid_i   (dec_term_valid),
        .done_i         (dec_done),
        .bias_i         (dec_bias),
        .data_i         (dec_data),
        .weight_i       (dec_weight),
        .sum_valid_o    (exe_sum_valid),
        .sum_o          (exe_sum)
    );

    // done at edge N gives output_valid_o after edge N+3
    ip_result u_result (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .relu_en_i      (relu_en_i),
        .onn_i          (onn_i),
        .sum_valid_i    (exe_sum_valid),
        .sum_i          (exe_sum),
        .output_valid_o (output_valid_o),
        .accum_data_o   (accum_data_o),
        .accum_addr_o   (accum_addr_o)
    );

endmodule

// ==== verilog/ip_result.sv ====
`timescale 1ns/1ps

module ip_result (
    input  logic                              clk_i,
    input  logic                              rstn_i,
    input  logic                              relu_en_i,
    input  logic [ip_pkg::CNT_W-1:0]          onn_i,
    input  logic                              sum_valid_i,
    input  logic signed [ip_pkg::WORD_W-1:0]  sum_i,
    output logic                              output_valid_o,
    output logic [ip_pkg::WORD_W-1:0]         accum_data_o,
    output logic [ip_pkg::ADDR_W-1:0]         accum_addr_o
);
    import ip_pkg::*;

    logic [WORD_W-1:0] relu_sum;
    logic [CNT_W-1:0]  last_addr;
    logic              addr_wrap;

    // clamp negative sums when ReLU is on
    assign relu_sum = (relu_en_i && sum_i[WORD_W-1]) ? '0 : sum_i;

    // highest address of the layer
    assign last_addr = onn_i - 1'b1;
    assign addr_wrap = (CNT_W'(accum_addr_o) == last_addr);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            output_valid_o <= 1'b0;
            accum_data_o   <= '0;
        end else begin
            output_valid_o <= sum_valid_i;
            // data bus idles at zero between outputs
            accum_data_o   <= sum_valid_i ? relu_sum : '0;
        end
    end

    //======================================================================
    //  output neuron address
    //======================================================================
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            accum_addr_o <= '0;
        end else if (output_valid_o) begin
            if (addr_wrap) begin
                accum_addr_o <= '0;
            end else begin
                accum_addr_o <= accum_addr_o + 1'b1;
            end
        end
    end

endmodule

// ==== verilog/ip_execute.sv ====
`timescale 1ns/1ps

module ip_execute (
    input  logic                              clk_i,
    input  logic                              rstn_i,
    input  logic                              bias_valid_i,
    input  logic                              term_valid_i,
    input  logic                              done_i,
    input  ip_pkg::word_u                     bias_i,
    input  ip_pkg::word_u                     data_i,
    input  ip_pkg::word_u                     weight_i,
    output logic                              sum_valid_o,
    output logic signed [ip_pkg::WORD_W-1:0]  sum_o
);
    import ip_pkg::*;

    // stage one
    logic signed [2*WORD_W-1:0] full_prod;
    logic signed [2*WORD_W-1:0] prod_shift;
    logic signed [WORD_W-1:0]   prod_q;
    logic signed [WORD_W-1:0]   bias_q;
    logic                       bias_vld_q;
    logic                       term_vld_q;
    logic                       done_q;

    // stage two
    logic signed [WORD_W-1:0]   acc_q;
    logic signed [WORD_W-1:0]   acc_base;
    logic signed [WORD_W-1:0]   acc_add;
    logic signed [WORD_W-1:0]   acc_next;

    //======================================================================
    //  stage one: fixed-point product
    //======================================================================
    assign full_prod  = $signed(data_i.word) * $signed(weight_i.word);
    assign prod_shift = full_prod >>> FRAC_W;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            bias_vld_q <= 1'b0;
            term_vld_q <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            bias_vld_q <= bias_valid_i;
            term_vld_q <= term_valid_i;
            done_q     <= done_i;
        end
    end

    // product keeps the integer part's low bits, overflow wraps
    always_ff @(posedge clk_i) begin
        prod_q <= prod_shift[WORD_W-1:0];
        bias_q <= bias_i.word;
    end

    //======================================================================
    //  stage two: accumulate
    //======================================================================
    // a bias restarts the neuron, a term in the same cycle rides on top
    assign acc_base = bias_vld_q ? bias_q : acc_q;
    assign acc_add  = term_vld_q ? prod_q : '0;
    assign acc_next = acc_base + acc_add;

    always_ff @(posedge clk_i) begin
        if (bias_vld_q || term_vld_q) begin
            acc_q <= acc_next;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            sum_valid_o <= 1'b0;
        end else begin
            sum_valid_o <= done_q;
        end
    end

    // the finished value includes the term of the done cycle,
    // so the next bias may load acc_q on the following edge
    always_ff @(posedge clk_i) begin
        if (done_q) begin
            sum_o <= acc_next;
        end
    end

endmodule

// ==== verilog/ip_decode.sv ====
`timescale 1ns/1ps

module ip_decode (
    input  logic          clk_i,
    input  logic          rstn_i,
    input  logic [1:0]    bend_i,
    input  logic          bias_valid_i,
    input  logic          data_valid_i,
    input  logic          weight_valid_i,
    input  logic          neuron_done_i,
    input  ip_pkg::word_u bias_i,
    input  ip_pkg::word_u data_i,
    input  ip_pkg::word_u weight_i,
    output logic          bias_valid_o,
    output logic          term_valid_o,
    output logic          done_o,
    output ip_pkg::word_u bias_o,
    output ip_pkg::word_u data_o,
    output ip_pkg::word_u weight_o
);
    import ip_pkg::*;

    word_u data_fix;
    word_u weight_fix;
    word_u bias_fix;

    // lane 0 goes to the top and so on
    function automatic word_u swap_bytes(input word_u w);
        word_u r;
        for (int i = 0; i < NUM_BYTES; i++) begin
            r.bytes[i] = w.bytes[NUM_BYTES-1-i];
        end
        return r;
    endfunction

    // bend bit low means the operand arrives in the other byte order
    assign data_fix   = bend_i[0] ? data_i   : swap_bytes(data_i);
    assign weight_fix = bend_i[1] ? weight_i : swap_bytes(weight_i);
    assign bias_fix   = bend_i[1] ? bias_i   : swap_bytes(bias_i);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            bias_valid_o <= 1'b0;
            term_valid_o <= 1'b0;
            done_o       <= 1'b0;
        end else begin
            bias_valid_o <= bias_valid_i;
            // a term needs both operands in the same cycle
            term_valid_o <= data_valid_i & weight_valid_i;
            done_o       <= neuron_done_i;
        end
    end

    always_ff @(posedge clk_i) begin
        bias_o   <= bias_fix;
        data_o   <= data_fix;
        weight_o <= weight_fix;
    end

endmodule

// ==== verilog/ip_pkg.sv ====
package ip_pkg;

    //======================================================================
    //  word and address widths
    //======================================================================
    localparam int WORD_W    = 32;
    localparam int BYTE_W    = 8;
    localparam int NUM_BYTES = WORD_W / BYTE_W;

    // signed Q15.16 operands and results
    localparam int FRAC_W = 16;

    // up to 4096 output neurons per layer
    localparam int ADDR_W = 12;
    localparam int CNT_W  = 13;

    //======================================================================
    //  input word views
    //======================================================================
    // one bus word, seen either as a signed number or as byte lanes
    typedef union packed {
        logic signed [WORD_W-1:0]           word;
        logic [NUM_BYTES-1:0][BYTE_W-1:0]   bytes;
    } word_u;

endpackage
